// File: design/mem_stage_params.svh
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// ********************************************************************
// datapath widths, all fixed by rv64i
// ********************************************************************
`define XLEN      64   // data and pc
`define ILEN      32   // instruction word
`define ADDR_W    32   // wishbone address
`define SEL_W     8    // one select per byte lane
`define REG_IDX_W 5    // x0..x31

// ********************************************************************
// instruction field positions
// ********************************************************************
`define RD_LSB    7    // rd = inst[11:7]
`define F3_LSB    12   // funct3 = inst[14:12]
`define RS2_LSB   20   // rs2 = inst[24:20]

`endif

// File: design/mem_stage_pkg.sv
package mem_stage_pkg;

    // write-back source, decoded upstream in EX
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,   // bubble or no rd write
        OP_ALU   = 3'd1,   // alu result
        OP_LINK  = 3'd2,   // jal / jalr, pc+4
        OP_CSR   = 3'd3,   // csr old value rides in src2
        OP_LOAD  = 3'd4,
        OP_STORE = 3'd5
    } mem_op_t;

    // load/store funct3 as the isa encodes it
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_D  = 3'b011,
        F3_BU = 3'b100,
        F3_HU = 3'b101,
        F3_WU = 3'b110
    } funct3_t;

    // data bus master
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,   // no access pending
        ST_ACCESS = 2'd1,   // cyc/stb up, waiting for ack
        ST_DONE   = 2'd2    // result held until the stage advances
    } bus_state_t;

endpackage

// File: design/mem_pipe_reg.sv
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_pipe_reg import mem_stage_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // from ex
    input  logic                valid_in,
    input  logic [`XLEN-1:0]    pc_in,
    input  logic [`ILEN-1:0]    inst_in,
    input  mem_op_t             op_in,
    input  logic [`XLEN-1:0]    alu_out_in,
    input  logic [`XLEN-1:0]    src2_in,
    // flow control
    input  logic                ready_out,
    input  logic                mem_hold,
    output logic                ready_in,
    output logic                advance,
    // registered fields
    output logic                valid_q,
    output logic [`XLEN-1:0]    pc_q,
    output logic [`ILEN-1:0]    inst_q,
    output mem_op_t             op_q,
    output logic [`XLEN-1:0]    alu_out_q,
    output logic [`XLEN-1:0]    src2_q
);

    // stage moves when wb takes our slot and no bus access is open
    assign advance  = ready_out & ~mem_hold;
    assign ready_in = advance;   // ex sees the same stall

    // ********************************************************************
    // ex/mem register
    // ********************************************************************

    // control part
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            op_q    <= OP_NONE;
        end else if (advance) begin
            valid_q <= valid_in;    // bubble if ex has nothing
            op_q    <= op_in;
        end
    end

    // payload, held while stalled
    always_ff @(posedge clk) begin
        if (advance) begin
            pc_q      <= pc_in;
            inst_q    <= inst_in;
            alu_out_q <= alu_out_in;   // also the mem address
            src2_q    <= src2_in;      // store data / csr value
        end
    end

endmodule

// File: design/store_align.sv
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module store_align import mem_stage_pkg::*; (
    input  logic [`ILEN-1:0]        inst_q,
    input  logic [`XLEN-1:0]        alu_out_q,
    input  logic [`XLEN-1:0]        src2_q,
    // wb feedback for forwarding
    input  logic                    wb_wen,
    input  logic [`REG_IDX_W-1:0]   wb_rd,
    input  logic [`XLEN-1:0]        wb_wdata,
    output logic [`XLEN-1:0]        st_data,
    output logic [`SEL_W-1:0]       st_sel
);

    logic [`REG_IDX_W-1:0] rs2;
    logic                  fwd_hit;
    logic [`XLEN-1:0]      st_src;
    logic [2:0]            lane;      // byte offset within the doubleword
    funct3_t               f3;

    assign rs2  = inst_q[`RS2_LSB +: `REG_IDX_W];
    assign f3   = funct3_t'(inst_q[`F3_LSB +: $bits(funct3_t)]);
    assign lane = alu_out_q[2:0];

    // ********************************************************************
    // forwarding from wb
    // ********************************************************************
    // a load just ahead of this store may still be writing rs2
    assign fwd_hit = wb_wen && (wb_rd == rs2);
    assign st_src  = fwd_hit ? wb_wdata : src2_q;

    // ********************************************************************
    // lane placement
    // ********************************************************************
    // low bytes of the source land at the addressed lane
    assign st_data = st_src << {lane, 3'b000};

    always_comb begin
        case (f3)
            F3_B:    st_sel = `SEL_W'(8'h01) << lane;   // sb
            F3_H:    st_sel = `SEL_W'(8'h03) << lane;   // sh, lane even
            F3_W:    st_sel = `SEL_W'(8'h0f) << lane;   // sw, lane 0 or 4
            F3_D:    st_sel = `SEL_W'(8'hff);           // sd
            default: st_sel = '0;   // not a store width
        endcase
    end

endmodule

// File: design/load_align.sv
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module load_align import mem_stage_pkg::*; (
    input  logic [`ILEN-1:0] inst_q,
    input  logic [`XLEN-1:0] alu_out_q,
    input  logic [`XLEN-1:0] rd_word,    // captured bus doubleword
    output logic [`XLEN-1:0] ld_data
);

    logic [2:0]       lane;
    logic [`XLEN-1:0] shifted;   // addressed bytes moved down to lane 0
    funct3_t          f3;

    assign f3   = funct3_t'(inst_q[`F3_LSB +: $bits(funct3_t)]);
    assign lane = alu_out_q[2:0];

    // aligned accesses only, so the item never crosses the top
    assign shifted = rd_word >> {lane, 3'b000};

    // ********************************************************************
    // width select and extension
    // ********************************************************************
    always_comb begin
        case (f3)
            F3_B:  ld_data = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};      // lb
            F3_H:  ld_data = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};   // lh
            F3_W:  ld_data = {{(`XLEN-32){shifted[31]}}, shifted[31:0]};   // lw
            F3_D:  ld_data = shifted;                                      // ld
            F3_BU: ld_data = {{(`XLEN-8){1'b0}}, shifted[7:0]};
            F3_HU: ld_data = {{(`XLEN-16){1'b0}}, shifted[15:0]};
            F3_WU: ld_data = {{(`XLEN-32){1'b0}}, shifted[31:0]};
            default: begin
                ld_data = rd_word;   // reserved funct3, raw word
            end
        endcase
    end

endmodule

// File: design/dmem_wb_master.sv
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module dmem_wb_master import mem_stage_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_q,
    input  mem_op_t             op_q,
    input  logic [`XLEN-1:0]    alu_out_q,
    input  logic [`XLEN-1:0]    st_data,
    input  logic [`SEL_W-1:0]   st_sel,
    input  logic                advance,
    output logic                mem_hold,
    output logic [`XLEN-1:0]    rd_word,
    // wishbone classic
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`ADDR_W-1:0]  wb_adr,
    output logic [`XLEN-1:0]    wb_dat_w,
    output logic [`SEL_W-1:0]   wb_sel,
    input  logic                wb_ack,
    input  logic [`XLEN-1:0]    wb_dat_r
);

    bus_state_t state;
    logic       mem_op;     // registered op needs the bus
    logic       is_store;
    logic       start;      // leaving idle this cycle

    assign is_store = (op_q == OP_STORE);
    assign mem_op   = valid_q && (is_store || op_q == OP_LOAD);
    assign start    = (state == ST_IDLE) && mem_op;

    // stall everything until the access has finished
    assign mem_hold = mem_op && (state != ST_DONE);

    // ********************************************************************
    // bus fsm
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            wb_we <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_ACCESS;
                        wb_we <= is_store;
                    end
                end
                ST_ACCESS: if (wb_ack) state <= ST_DONE;   // any number of waits
                ST_DONE:   if (advance) state <= ST_IDLE;  // wb has taken it
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // cyc and stb together for single classic cycles
    assign wb_cyc = (state == ST_ACCESS);
    assign wb_stb = wb_cyc;

    // request fields frozen for the whole access
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= alu_out_q[`ADDR_W-1:0];
            wb_dat_w <= st_data;
            wb_sel   <= is_store ? st_sel : {`SEL_W{1'b1}};   // loads read all lanes
        end
        if (wb_cyc && wb_ack)
            rd_word <= wb_dat_r;   // lane pick happens in load_align
    end

endmodule

// File: design/writeback_mux.sv
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module writeback_mux import mem_stage_pkg::*; (
    input  logic                    valid_q,
    input  logic                    mem_hold,
    input  mem_op_t                 op_q,
    input  logic [`XLEN-1:0]        pc_q,
    input  logic [`ILEN-1:0]        inst_q,
    input  logic [`XLEN-1:0]        alu_out_q,
    input  logic [`XLEN-1:0]        src2_q,
    input  logic [`XLEN-1:0]        ld_data,
    output logic                    valid_out,
    output logic [`XLEN-1:0]        pc_out,
    output logic [`ILEN-1:0]        inst_out,
    output logic                    reg_wr_wen,
    output logic [`REG_IDX_W-1:0]   reg_wr_rd,
    output logic [`XLEN-1:0]        reg_wr_value
);

    logic writes_rd;

    // memory ops show up only after the bus finishes
    assign valid_out = valid_q & ~mem_hold;
    assign pc_out    = pc_q;
    assign inst_out  = inst_q;

    // ********************************************************************
    // register file write
    // ********************************************************************
    always_comb begin
        writes_rd    = 1'b1;
        reg_wr_value = alu_out_q;
        case (op_q)
            OP_ALU:  reg_wr_value = alu_out_q;
            OP_LINK: reg_wr_value = pc_q + `XLEN'(4);   // return address
            OP_CSR:  reg_wr_value = src2_q;   // old csr, not forwarded
            OP_LOAD: reg_wr_value = ld_data;
            default: writes_rd    = 1'b0;     // none, store
        endcase
    end

    assign reg_wr_wen = valid_out & writes_rd;
    assign reg_wr_rd  = inst_q[`RD_LSB +: `REG_IDX_W];

endmodule

// File: design/mem_stage_top.sv
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_stage_top import mem_stage_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // upstream, ex stage
    input  logic                    valid_in,
    output logic                    ready_in,
    input  logic [`XLEN-1:0]        pc_in,
    input  logic [`ILEN-1:0]        inst_in,
    input  mem_op_t                 op_in,
    input  logic [`XLEN-1:0]        alu_out_in,
    input  logic [`XLEN-1:0]        src2_in,
    // downstream, wb stage
    output logic                    valid_out,
    input  logic                    ready_out,
    output logic [`XLEN-1:0]        pc_out,
    output logic [`ILEN-1:0]        inst_out,
    output logic                    reg_wr_wen,
    output logic [`REG_IDX_W-1:0]   reg_wr_rd,
    output logic [`XLEN-1:0]        reg_wr_value,
    // wb stage feedback
    input  logic                    wb_wen,
    input  logic [`REG_IDX_W-1:0]   wb_rd,
    input  logic [`XLEN-1:0]        wb_wdata,
    // data memory, wishbone classic
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`ADDR_W-1:0]      wb_adr,
    output logic [`XLEN-1:0]        wb_dat_w,
    output logic [`SEL_W-1:0]       wb_sel,
    input  logic                    wb_ack,
    input  logic [`XLEN-1:0]        wb_dat_r
);

    logic               advance;
    logic               mem_hold;
    logic               valid_q;
    logic [`XLEN-1:0]   pc_q;
    logic [`ILEN-1:0]   inst_q;
    mem_op_t            op_q;
    logic [`XLEN-1:0]   alu_out_q;
    logic [`XLEN-1:0]   src2_q;
    logic [`XLEN-1:0]   st_data;
    logic [`SEL_W-1:0]  st_sel;
    logic [`XLEN-1:0]   rd_word;
    logic [`XLEN-1:0]   ld_data;

    mem_pipe_reg u_pipe_reg (
        .clk(clk), .rst(rst),
        .valid_in(valid_in), .pc_in(pc_in), .inst_in(inst_in), .op_in(op_in),
        .alu_out_in(alu_out_in), .src2_in(src2_in),
        .ready_out(ready_out), .mem_hold(mem_hold),
        .ready_in(ready_in), .advance(advance),
        .valid_q(valid_q), .pc_q(pc_q), .inst_q(inst_q), .op_q(op_q),
        .alu_out_q(alu_out_q), .src2_q(src2_q)
    );

    store_align u_store_align (
        .inst_q(inst_q), .alu_out_q(alu_out_q), .src2_q(src2_q),
        .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_wdata(wb_wdata),
        .st_data(st_data), .st_sel(st_sel)
    );

    dmem_wb_master u_dmem (
        .clk(clk), .rst(rst),
        .valid_q(valid_q), .op_q(op_q), .alu_out_q(alu_out_q),
        .st_data(st_data), .st_sel(st_sel), .advance(advance),
        .mem_hold(mem_hold), .rd_word(rd_word),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
    );

    load_align u_load_align (
        .inst_q(inst_q), .alu_out_q(alu_out_q), .rd_word(rd_word),
        .ld_data(ld_data)
    );

    writeback_mux u_wb_mux (
        .valid_q(valid_q), .mem_hold(mem_hold), .op_q(op_q),
        .pc_q(pc_q), .inst_q(inst_q), .alu_out_q(alu_out_q),
        .src2_q(src2_q), .ld_data(ld_data),
        .valid_out(valid_out), .pc_out(pc_out), .inst_out(inst_out),
        .reg_wr_wen(reg_wr_wen), .reg_wr_rd(reg_wr_rd), .reg_wr_value(reg_wr_value)
    );

endmodule

// File: dv/dmem_model.sv
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module dmem_model (
    input  logic                clk,
    input  logic                rst,
    input  logic [1:0]          wait_n,     // wait states before ack
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [`ADDR_W-1:0]  wb_adr,
    input  logic [`XLEN-1:0]    wb_dat_w,
    input  logic [`SEL_W-1:0]   wb_sel,
    output logic                wb_ack,
    output logic [`XLEN-1:0]    wb_dat_r
);

    logic [`XLEN-1:0] mem [0:63];   // preloaded and inspected by the testbench
    logic [1:0]       wait_cnt;
    logic [5:0]       idx;

    assign idx = wb_adr[8:3];   // doubleword index

    // ********************************************************************
    // classic slave, one ack per cycle
    // ********************************************************************
    always @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (wait_cnt == wait_n) begin
                wb_ack   <= 1'b1;
                wait_cnt <= 2'd0;
                wb_dat_r <= mem[idx];
                for (int b = 0; b < `SEL_W; b++)
                    if (wb_we && wb_sel[b])
                        mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];   // selected lanes only
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end else begin
            wb_ack <= 1'b0;   // master drops cyc after ack
        end
    end

endmodule

// File: dv/tb_mem_stage.sv
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module tb_mem_stage import mem_stage_pkg::*; ();

    localparam int N_OPS       = 5 + 29 + 30 + 3 + 1;       // nonmem, loads, stores, fwd, bp
    localparam int WATCHDOG_NS = (N_OPS * 8 + 100) * 100;

    logic                    clk        = 1'b0;
    logic                    rst        = 1'b1;
    logic                    valid_in   = 1'b0;
    logic                    ready_in;
    logic [`XLEN-1:0]        pc_in      = '0;
    logic [`ILEN-1:0]        inst_in    = '0;
    mem_op_t                 op_in      = OP_NONE;
    logic [`XLEN-1:0]        alu_out_in = '0;
    logic [`XLEN-1:0]        src2_in    = '0;
    logic                    valid_out;
    logic                    ready_out  = 1'b1;
    logic [`XLEN-1:0]        pc_out;
    logic [`ILEN-1:0]        inst_out;
    logic                    reg_wr_wen;
    logic [`REG_IDX_W-1:0]   reg_wr_rd;
    logic [`XLEN-1:0]        reg_wr_value;
    logic                    wb_wen     = 1'b0;
    logic [`REG_IDX_W-1:0]   wb_rd      = '0;
    logic [`XLEN-1:0]        wb_wdata   = '0;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`ADDR_W-1:0]      wb_adr;
    logic [`XLEN-1:0]        wb_dat_w;
    logic [`SEL_W-1:0]       wb_sel;
    logic                    wb_ack;
    logic [`XLEN-1:0]        wb_dat_r;
    logic [1:0]              wait_n     = 2'd0;
    logic [31:0]             lfsr_state = 32'heb00_e5db;

    mem_stage_top DUT (.*);

    dmem_model slave (
        .clk(clk), .rst(rst), .wait_n(wait_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
    );

    always #50 clk = ~clk;   // 100 ns period

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, a handshake never completed");
        abort_run();
    end

    // ********************************************************************
    // helpers
    // ********************************************************************
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[62:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic int access_bytes(input funct3_t f3);
        case (f3)
            F3_B, F3_BU: return 1;
            F3_H, F3_HU: return 2;
            F3_W, F3_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic logic [31:0] encode_inst(input funct3_t f3, input logic [4:0] rd,
                                                input logic [4:0] rs2);
        return {7'd0, rs2, 5'd1, f3, rd, 7'b0000011};   // rs1 fixed at x1
    endfunction

    // byte lanes the bus request must enable
    function automatic logic [7:0] bus_select(input mem_op_t op, input funct3_t f3,
                                              input int lane);
        logic [7:0] r;
        r = 8'hff;   // loads read every lane
        if (op == OP_STORE)
            r = 8'((1 << access_bytes(f3)) - 1) << lane;
        return r;
    endfunction

    // item at the lane, then extension
    function automatic logic [63:0] load_expect(input logic [63:0] dw, input int lane,
                                                input funct3_t f3);
        logic [63:0] item;
        logic [63:0] r;
        item = dw >> (8 * lane);
        case (f3)
            F3_B:    r = $signed(item[7:0]);
            F3_H:    r = $signed(item[15:0]);
            F3_W:    r = $signed(item[31:0]);
            F3_BU:   r = item[7:0];
            F3_HU:   r = item[15:0];
            F3_WU:   r = item[31:0];
            default: r = item;   // ld
        endcase
        return r;
    endfunction

    function automatic logic [63:0] store_merge(input logic [63:0] old, input logic [63:0] data,
                                                input int lane, input int nbytes);
        logic [63:0] r;
        r = old;
        for (int k = 0; k < nbytes; k++)
            r[8*(lane+k) +: 8] = data[8*k +: 8];   // low source bytes from the lane up
        return r;
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // drive on the current edge, return on the transfer edge
    task automatic drive_op(input mem_op_t op, input funct3_t f3, input logic [4:0] rd,
                            input logic [4:0] rs2, input logic [63:0] pc,
                            input logic [63:0] alu, input logic [63:0] src2);
        valid_in   <= 1'b1;
        pc_in      <= pc;
        inst_in    <= encode_inst(f3, rd, rs2);
        op_in      <= op;
        alu_out_in <= alu;
        src2_in    <= src2;
        wait_n     <= 2'(rand_bits(2));
        do @(posedge clk); while (!ready_in);
        valid_in   <= 1'b0;
        op_in      <= OP_NONE;
    endtask

    task automatic run_op(input mem_op_t op, input funct3_t f3, input logic [4:0] rd,
                          input logic [4:0] rs2, input logic [63:0] pc, input logic [63:0] alu,
                          input logic [63:0] src2, output logic wen, output logic [4:0] rd_seen,
                          output logic [63:0] value);
        drive_op(op, f3, rd, rs2, pc, alu, src2);
        if (op == OP_LOAD || op == OP_STORE) begin
            do begin
                @(posedge clk);   // bus latency varies
                if (wb_cyc) begin
                    check_value("bus address", alu[`ADDR_W-1:0], wb_adr);
                    check_value("bus write enable", op == OP_STORE, wb_we);
                    check_value("bus byte selects", bus_select(op, f3, alu[2:0]), wb_sel);
                    check_value("bus strobe", 1, wb_stb);
                end
            end while (!valid_out);
        end else begin
            @(posedge clk);
            assert (valid_out) else begin
                $display("valid_out was low in the cycle after the transfer");
                abort_run();
            end
        end
        check_value("pc_out", pc, pc_out);
        check_value("inst_out", encode_inst(f3, rd, rs2), inst_out);
        wen     = reg_wr_wen;
        rd_seen = reg_wr_rd;
        value   = reg_wr_value;
    endtask

    // ********************************************************************
    // directed tests
    // ********************************************************************
    task automatic reset_values();
        @(posedge clk);
        check_value("reset valid_out", 0, valid_out);
        check_value("reset reg_wr_wen", 0, reg_wr_wen);
        check_value("reset wb_cyc", 0, wb_cyc);
        check_value("reset wb_stb", 0, wb_stb);
        check_value("reset ready_in high", 1, ready_in);
        ready_out <= 1'b0;
        @(posedge clk);
        check_value("reset ready_in low", 0, ready_in);   // follows ready_out
        ready_out <= 1'b1;
    endtask

    task automatic nonmem_writeback();
        mem_op_t     ops [5];
        logic [63:0] pc;
        logic [63:0] alu;
        logic [63:0] src2;
        logic [63:0] exp;
        logic        writes;
        logic        wen;
        logic [4:0]  rd_seen;
        logic [63:0] val;
        ops = '{OP_ALU, OP_LINK, OP_CSR, OP_NONE, OP_STORE};
        for (int i = 0; i < 5; i++) begin
            pc   = rand_bits(64);
            src2 = rand_bits(64);
            alu  = (ops[i] == OP_STORE) ? {6'(rand_bits(6)), 3'b000} : rand_bits(64);
            wb_wen   <= (ops[i] == OP_CSR);   // csr value must ignore forwarding
            wb_rd    <= 5'd6;
            wb_wdata <= ~src2;
            run_op(ops[i], F3_D, 5'(5 + i), 5'd6, pc, alu, src2, wen, rd_seen, val);
            wb_wen   <= 1'b0;
            case (ops[i])
                OP_ALU:  exp = alu;
                OP_LINK: exp = pc + 64'd4;
                OP_CSR:  exp = src2;
                default: exp = '0;
            endcase
            writes = (ops[i] == OP_ALU) || (ops[i] == OP_LINK) || (ops[i] == OP_CSR);
            check_value($sformatf("nonmem op=%0d wen", ops[i]), writes, wen);
            if (writes) begin
                check_value($sformatf("nonmem op=%0d value", ops[i]), exp, val);
                check_value($sformatf("nonmem op=%0d rd", ops[i]), 5 + i, rd_seen);
            end
        end
    endtask

    task automatic load_widths();
        funct3_t     f3_list [7];
        logic [5:0]  idx;
        logic [63:0] dw;
        logic        wen;
        logic [4:0]  rd_seen;
        logic [63:0] val;
        f3_list = '{F3_B, F3_H, F3_W, F3_D, F3_BU, F3_HU, F3_WU};
        for (int i = 0; i < 64; i++)
            slave.mem[i] = rand_bits(64);
        for (int w = 0; w < 7; w++) begin
            for (int lane = 0; lane < 8; lane += access_bytes(f3_list[w])) begin
                idx = 6'(rand_bits(6));
                dw  = slave.mem[idx];
                run_op(OP_LOAD, f3_list[w], 5'(lane + 8), 5'd2, 64'h100, {idx, 3'(lane)},
                       64'd0, wen, rd_seen, val);
                check_value($sformatf("load f3=%0d lane=%0d", f3_list[w], lane),
                            load_expect(dw, lane, f3_list[w]), val);
                check_value("load wen", 1, wen);
                check_value("load rd", lane + 8, rd_seen);
            end
        end
    endtask

    task automatic store_lanes();
        funct3_t     f3_list [4];
        logic [5:0]  idx;
        logic [63:0] data;
        logic [63:0] exp;
        logic        wen;
        logic [4:0]  rd_seen;
        logic [63:0] val;
        f3_list = '{F3_B, F3_H, F3_W, F3_D};
        for (int w = 0; w < 4; w++) begin
            for (int lane = 0; lane < 8; lane += access_bytes(f3_list[w])) begin
                idx  = 6'(rand_bits(6));
                data = rand_bits(64);
                exp  = store_merge(slave.mem[idx], data, lane, access_bytes(f3_list[w]));
                run_op(OP_STORE, f3_list[w], 5'd0, 5'd9, 64'h200, {idx, 3'(lane)}, data,
                       wen, rd_seen, val);
                check_value("store wen", 0, wen);
                check_value($sformatf("store f3=%0d lane=%0d mem", f3_list[w], lane),
                            exp, slave.mem[idx]);
                run_op(OP_LOAD, F3_D, 5'd3, 5'd0, 64'h204, {idx, 3'b000}, 64'd0,
                       wen, rd_seen, val);
                check_value($sformatf("store f3=%0d lane=%0d readback", f3_list[w], lane),
                            exp, val);
            end
        end
    endtask

    task automatic store_forwarding();
        logic        fwd_en [3];
        logic        rd_match [3];
        logic [5:0]  idx;
        logic [63:0] src2;
        logic [63:0] wdata;
        logic        wen;
        logic [4:0]  rd_seen;
        logic [63:0] val;
        fwd_en   = '{1'b1, 1'b1, 1'b0};
        rd_match = '{1'b1, 1'b0, 1'b1};
        for (int i = 0; i < 3; i++) begin
            idx   = 6'(rand_bits(6));
            src2  = rand_bits(64);
            wdata = rand_bits(64);
            wb_wen   <= fwd_en[i];
            wb_rd    <= rd_match[i] ? 5'd12 : 5'd13;   // rs2 is x12
            wb_wdata <= wdata;
            run_op(OP_STORE, F3_D, 5'd0, 5'd12, 64'h300, {idx, 3'b000}, src2,
                   wen, rd_seen, val);
            wb_wen   <= 1'b0;
            check_value($sformatf("forwarding case %0d", i),
                        (fwd_en[i] && rd_match[i]) ? wdata : src2, slave.mem[idx]);
        end
    endtask

    task automatic ready_backpressure();
        logic [5:0]  idx;
        logic [63:0] exp;
        logic [63:0] held;
        int          accepted;
        idx = 6'(rand_bits(6));
        exp = load_expect(slave.mem[idx], 4, F3_W);   // upper word, signed
        drive_op(OP_LOAD, F3_W, 5'd17, 5'd0, 64'h400, {idx, 3'd4}, 64'd0);
        ready_out <= 1'b0;   // wb stalls while the access runs
        do @(posedge clk); while (!valid_out);
        held = reg_wr_value;
        check_value("backpressure value", exp, held);
        repeat (4) begin
            @(posedge clk);
            check_value("backpressure ready_in", 0, ready_in);
            check_value("backpressure valid_out", 1, valid_out);
            check_value("backpressure hold", held, reg_wr_value);
        end
        ready_out <= 1'b1;
        accepted = 0;
        repeat (4) begin
            @(posedge clk);
            if (valid_out && ready_out)
                accepted++;
        end
        check_value("backpressure write-backs", 1, accepted);
    endtask

    // ********************************************************************
    // sequence
    // ********************************************************************
    initial begin
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_values();
        nonmem_writeback();
        load_widths();
        store_lanes();
        store_forwarding();
        ready_backpressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: sources.f
+incdir+design
design/mem_stage_pkg.sv
design/mem_pipe_reg.sv
design/store_align.sv
design/load_align.sv
design/dmem_wb_master.sv
design/writeback_mux.sv
design/mem_stage_top.sv
dv/dmem_model.sv
dv/tb_mem_stage.sv
